// File: build.f
common/fe_pkg.sv
rtl/pc_gen.sv
rtl/fetch_stage.sv
rtl/fetch_queue.sv
rtl/decode_stage.sv
rtl/frontend_top.sv
test/tb_clock.sv
test/tb_frontend.sv

// File: run_sim.sh
#!/bin/sh
# build the front end testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
    --top-module tb_frontend -o tb_frontend_sim &&
./obj_dir/tb_frontend_sim || exit 1

// File: test/tb_frontend.sv
`default_nettype none

module tb_frontend;

    timeunit 1ns;
    timeprecision 1ps;

    import fe_pkg::*;

    localparam logic [31:0] first_pc = 32'h8000_0000;
    localparam int prog_words      = 64;
    localparam int n_issue         = 200;
    localparam int n_redirect      = 5;
    localparam int redirect_every  = 35;            // issued instructions between redirects
    localparam int watchdog_cycles = n_issue * 15;  // loose bound per instruction

    logic        clk;
    logic        rst_n;
    logic        imem_req_valid;
    logic        imem_req_ready;
    logic [31:0] imem_req_addr;
    logic        imem_rsp_valid;
    logic [31:0] imem_rsp_data;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        issue_valid;
    logic        issue_ready;
    logic [31:0] issue_pc;
    logic [31:0] issue_instr;
    logic [1:0]  issue_kind;

    logic [31:0] prog [prog_words];
    integer      seed;
    logic [31:0] exp_pc;          // pc the next issue must carry
    int          issued;
    int          redirects;
    logic        first_req_seen;
    logic        mem_busy;        // memory owes one response
    logic [31:0] rsp_addr;
    int          rsp_wait;
    int          acc_wait;

    tb_clock clock_gen (.clk, .rst_n);

    frontend_top UUT (
        .clk, .rst_n,
        .imem_req_valid, .imem_req_ready, .imem_req_addr, .imem_rsp_valid, .imem_rsp_data,
        .redirect_valid, .redirect_pc,
        .issue_valid, .issue_ready, .issue_pc, .issue_instr, .issue_kind
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "stopping on first error");
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                          input logic [5:0] idx);
        return {funct7, ~idx[4:0], idx[5:1], funct3, idx[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_other(input logic [5:0] idx);
        logic [6:0] opcode;
        case (idx[1:0])
            2'd0:    opcode = 7'b0010011;  // addi
            2'd1:    opcode = 7'b0000011;  // lw
            2'd2:    opcode = 7'b0110111;  // lui
            default: opcode = 7'b0100011;  // sw
        endcase
        return {idx, idx, idx[4:0], 3'b010, idx[4:0], opcode};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};  // rd = ra
    endfunction

    function automatic logic [31:0] jal_offset(input logic [31:0] word);
        return {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    endfunction

    function automatic logic [1:0] expected_kind(input logic [31:0] word);
        if (word[6:0] == 7'b1101111)
            return kind_jal;
        if (word[6:0] == 7'b0110011)
            return (word[31:25] == 7'b0000001) ? kind_muldiv : kind_alu;
        return kind_other;
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return prog[addr[7:2]];
    endfunction

    task automatic build_program();
        for (int n = 0; n < prog_words; n++) begin
            case (n % 5)
                0:       prog[n] = enc_r(7'b0000000, 3'(n), 6'(n));   // alu ops
                1:       prog[n] = enc_r(7'b0100000, 3'b000, 6'(n));  // sub
                2:       prog[n] = enc_r(7'b0000001, 3'b000, 6'(n));  // mul
                3:       prog[n] = enc_r(7'b0000001, 3'b100, 6'(n));  // div
                default: prog[n] = enc_other(6'(n));
            endcase
        end
        // main path 0..10, 20..40, 50..63, then loops from 11
        prog[10] = enc_jal(21'(40));    // forward to 20
        prog[40] = enc_jal(21'(40));    // forward to 50
        prog[49] = enc_jal(21'(-188));  // back to 2, reached by redirect only
        prog[63] = enc_jal(21'(-208));  // back to 11
    endtask

    initial begin
        seed           = 32'he35786f9;
        imem_req_ready = 1'b0;
        imem_rsp_valid = 1'b0;
        imem_rsp_data  = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        issue_ready    = 1'b0;
        exp_pc         = first_pc;
        issued         = 0;
        redirects      = 0;
        first_req_seen = 1'b0;
        mem_busy       = 1'b0;
        rsp_addr       = '0;
        rsp_wait       = 0;
        acc_wait       = 0;
        build_program();
        while (issued < n_issue)
            @(posedge clk);
        @(negedge clk);
        $display("Test OK");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("timeout: %0d of %0d instructions issued in %0d cycles",
                            issued, n_issue, watchdog_cycles));
    end

    // sample handshakes on the rising edge, before any register moves
    always @(posedge clk) begin
        if (rst_n) begin
            if (imem_req_valid && !first_req_seen) begin
                first_req_seen = 1'b1;
                assert (imem_req_addr == first_pc)
                    else abort_run($sformatf("CHECK FAILED at time %0t: first fetch %h",
                                             $time, imem_req_addr));
            end
            if (imem_rsp_valid)
                mem_busy = 1'b0;
            if (imem_req_valid && imem_req_ready) begin
                mem_busy = 1'b1;
                rsp_addr = imem_req_addr;
                rsp_wait = $random(seed) & 3;
                acc_wait = $random(seed) & 3;  // stall before the next accept
            end
            if (issue_valid && issue_ready) begin
                assert (issue_pc == exp_pc)
                    else abort_run($sformatf("CHECK FAILED at time %0t: issue pc %h, expected %h",
                                             $time, issue_pc, exp_pc));
                assert (issue_instr == word_at(issue_pc))
                    else abort_run($sformatf("CHECK FAILED at time %0t: instr %h at %h, expected %h",
                                             $time, issue_instr, issue_pc, word_at(issue_pc)));
                assert (issue_kind == expected_kind(issue_instr))
                    else abort_run($sformatf("CHECK FAILED at time %0t: kind %0d for %h",
                                             $time, issue_kind, issue_instr));
                if (issue_instr[6:0] == 7'b1101111)
                    exp_pc = issue_pc + jal_offset(issue_instr);
                else
                    exp_pc = issue_pc + 32'd4;
                issued++;
            end
            if (redirect_valid)
                exp_pc = redirect_pc;  // younger than a same-cycle issue
        end
    end

    // memory model, back-end stalls and redirects
    always @(negedge clk) begin
        imem_rsp_valid = 1'b0;
        imem_req_ready = 1'b0;
        redirect_valid = 1'b0;
        issue_ready    = 1'b0;
        if (rst_n) begin
            if (mem_busy) begin
                if (rsp_wait == 0) begin
                    imem_rsp_valid = 1'b1;
                    imem_rsp_data  = word_at(rsp_addr);
                end else begin
                    rsp_wait--;
                end
            end else if (imem_req_valid) begin
                if (acc_wait == 0)
                    imem_req_ready = 1'b1;
                else
                    acc_wait--;
            end
            issue_ready = (($random(seed) & 3) != 0);  // low about a quarter of the time
            if (redirects < n_redirect && issued >= (redirects + 1) * redirect_every) begin
                redirect_valid = 1'b1;
                redirect_pc    = first_pc + (($random(seed) & 63) << 2);
                redirects++;
            end
        end
    end

    a_reset_quiet : assert property (
        @(posedge clk) $rose(rst_n) |-> !issue_valid && !imem_req_valid
    ) else abort_run($sformatf("CHECK FAILED at time %0t: valid high out of reset", $time));

    a_stall_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_valid && !issue_ready && !redirect_valid |=>
            issue_valid && $stable(issue_pc) && $stable(issue_instr) && $stable(issue_kind)
    ) else abort_run($sformatf("CHECK FAILED at time %0t: issue changed while stalled", $time));

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period = 10;  // 20 ns clock

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // reset over three rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: rtl/frontend_top.sv
`default_nettype none

module frontend_top (
    input  logic        clk,
    input  logic        rst_n,
    output logic        imem_req_valid,
    input  logic        imem_req_ready,
    output logic [31:0] imem_req_addr,
    input  logic        imem_rsp_valid,
    input  logic [31:0] imem_rsp_data,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    output logic        issue_valid,
    input  logic        issue_ready,
    output logic [31:0] issue_pc,
    output logic [31:0] issue_instr,
    output logic [1:0]  issue_kind
);

    logic        pc_valid;
    logic        pc_ready;
    logic [31:0] pc;
    logic        fq_in_valid;
    logic        fq_in_ready;
    logic [31:0] fq_in_pc;
    logic [31:0] fq_in_instr;
    logic        fq_out_valid;
    logic        fq_out_ready;
    logic [31:0] fq_out_pc;
    logic [31:0] fq_out_instr;
    logic        dec_redirect;
    logic [31:0] dec_target;
    logic        flush;

    assign flush = redirect_valid | dec_redirect;  // either source kills the fetched path

    pc_gen u_pc_gen (
        .clk, .rst_n, .redirect_valid, .redirect_pc, .dec_redirect, .dec_target,
        .pc_valid, .pc_ready, .pc
    );

    fetch_stage u_fetch_stage (
        .clk, .rst_n, .pc_valid, .pc_ready, .pc,
        .imem_req_valid, .imem_req_ready, .imem_req_addr, .imem_rsp_valid, .imem_rsp_data,
        .flush, .fq_in_valid, .fq_in_ready, .fq_in_pc, .fq_in_instr
    );

    fetch_queue u_fetch_queue (
        .clk, .rst_n, .flush, .fq_in_valid, .fq_in_ready, .fq_in_pc, .fq_in_instr,
        .fq_out_valid, .fq_out_ready, .fq_out_pc, .fq_out_instr
    );

    decode_stage u_decode_stage (
        .clk, .rst_n, .redirect_valid,
        .fq_out_valid, .fq_out_ready, .fq_out_pc, .fq_out_instr,
        .dec_redirect, .dec_target,
        .issue_valid, .issue_ready, .issue_pc, .issue_instr, .issue_kind
    );

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        redirect_valid,
    input  logic        fq_out_valid,
    output logic        fq_out_ready,
    input  logic [31:0] fq_out_pc,
    input  logic [31:0] fq_out_instr,
    output logic        dec_redirect,
    output logic [31:0] dec_target,
    output logic        issue_valid,
    input  logic        issue_ready,
    output logic [31:0] issue_pc,
    output logic [31:0] issue_instr,
    output logic [1:0]  issue_kind
);

    import fe_pkg::*;

    instr_u      instr;
    logic [1:0]  kind;
    logic [31:0] j_imm;
    logic        accept;

    assign instr = fq_out_instr;

    always_comb begin
        if (instr.j_fmt.opcode == op_jal)
            kind = kind_jal;
        else if (instr.r_fmt.opcode == op_op && instr.r_fmt.funct7 == funct7_muldiv)
            kind = kind_muldiv;
        else if (instr.r_fmt.opcode == op_op)
            kind = kind_alu;
        else
            kind = kind_other;
    end

    // J immediate, bit 0 always zero
    assign j_imm = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                    instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};
    assign dec_target = fq_out_pc + j_imm;

    // head of the queue is wrong path while the back end redirects
    assign fq_out_ready = (!issue_valid || issue_ready) && !redirect_valid;
    assign accept       = fq_out_valid && fq_out_ready;
    assign dec_redirect = accept && (kind == kind_jal);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            issue_valid <= 1'b0;
        else if (redirect_valid)
            issue_valid <= 1'b0;
        else if (accept)
            issue_valid <= 1'b1;
        else if (issue_ready)
            issue_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue_pc    <= fq_out_pc;
            issue_instr <= fq_out_instr;
            issue_kind  <= kind;
        end
    end

    // a stalled issue must not change under the back end
    a_issue_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_valid && !issue_ready && !redirect_valid |=>
            issue_valid && $stable(issue_pc) && $stable(issue_instr) && $stable(issue_kind)
    ) else $error("decode_stage: issue data changed while stalled");

endmodule

`default_nettype wire

// File: rtl/fetch_queue.sv
`default_nettype none

module fetch_queue (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        fq_in_valid,
    output logic        fq_in_ready,
    input  logic [31:0] fq_in_pc,
    input  logic [31:0] fq_in_instr,
    output logic        fq_out_valid,
    input  logic        fq_out_ready,
    output logic [31:0] fq_out_pc,
    output logic [31:0] fq_out_instr
);

    import fe_pkg::*;

    logic [31:0]         pc_q    [fq_depth];
    logic [31:0]         instr_q [fq_depth];
    logic [fq_ptr_w-1:0] rd_ptr;
    logic [fq_ptr_w-1:0] wr_ptr;
    logic [fq_cnt_w-1:0] count;
    logic                do_wr;
    logic                do_rd;

    assign fq_in_ready  = (count != fq_cnt_w'(fq_depth));  // low when full
    assign fq_out_valid = (count != '0);
    assign fq_out_pc    = pc_q[rd_ptr];
    assign fq_out_instr = instr_q[rd_ptr];
    assign do_wr        = fq_in_valid && fq_in_ready;
    assign do_rd        = fq_out_valid && fq_out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // drop everything fetched down the old path
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == fq_ptr_w'(fq_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == fq_ptr_w'(fq_depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            pc_q[wr_ptr]    <= fq_in_pc;
            instr_q[wr_ptr] <= fq_in_instr;
        end
    end

    a_count_bound : assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= fq_cnt_w'(fq_depth)
    ) else $error("fetch_queue: count %0d above depth", count);

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
`default_nettype none

module fetch_stage (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pc_valid,
    output logic        pc_ready,
    input  logic [31:0] pc,
    output logic        imem_req_valid,
    input  logic        imem_req_ready,
    output logic [31:0] imem_req_addr,
    input  logic        imem_rsp_valid,  // no ready, always taken
    input  logic [31:0] imem_rsp_data,
    input  logic        flush,
    output logic        fq_in_valid,
    input  logic        fq_in_ready,
    output logic [31:0] fq_in_pc,
    output logic [31:0] fq_in_instr
);

    logic        busy;        // one request in flight
    logic        stale;       // in-flight request belongs to a flushed path
    logic [31:0] req_pc;
    logic        hold_valid;  // kept response waiting for the queue
    logic        req_fire;
    logic        rsp_keep;

    // request only when nothing is in flight and nothing is held
    assign imem_req_valid = pc_valid && !busy && !hold_valid;
    assign imem_req_addr  = pc;
    assign pc_ready       = imem_req_ready && !busy && !hold_valid;
    assign req_fire       = imem_req_valid && imem_req_ready;
    assign rsp_keep       = imem_rsp_valid && busy && !stale && !flush;
    assign fq_in_valid    = hold_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            stale      <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            if (req_fire) begin
                busy  <= 1'b1;
                stale <= flush;  // pc sent this cycle is already wrong path
            end else begin
                if (imem_rsp_valid)
                    busy <= 1'b0;
                if (flush)
                    stale <= 1'b1;
            end
            if (flush)
                hold_valid <= 1'b0;
            else if (rsp_keep)
                hold_valid <= 1'b1;
            else if (fq_in_ready)
                hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire)
            req_pc <= pc;
        if (rsp_keep) begin
            fq_in_pc    <= req_pc;
            fq_in_instr <= imem_rsp_data;
        end
    end

    // memory must not answer a request that was never made
    a_rsp_outstanding : assert property (
        @(posedge clk) disable iff (!rst_n)
        imem_rsp_valid |-> busy
    ) else $error("fetch_stage: response with no request outstanding");

endmodule

`default_nettype wire

// File: rtl/pc_gen.sv
`default_nettype none

module pc_gen (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        redirect_valid,  // from the back end
    input  logic [31:0] redirect_pc,
    input  logic        dec_redirect,    // JAL taken in decode
    input  logic [31:0] dec_target,
    output logic        pc_valid,
    input  logic        pc_ready,
    output logic [31:0] pc
);

    import fe_pkg::*;

    logic        load_new;
    logic [31:0] new_pc;

    // external redirect wins over a decode redirect
    always_comb begin
        load_new = redirect_valid | dec_redirect;
        new_pc   = redirect_valid ? redirect_pc : dec_target;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= reset_pc;
            pc_valid <= 1'b0;
        end else begin
            pc_valid <= 1'b1;  // one idle cycle out of reset, then always valid
            if (load_new) begin
                pc <= new_pc;
            end else if (pc_valid && pc_ready) begin
                pc <= pc + 32'd4;  // sequential step
            end
        end
    end

    // no compressed instructions, so fetch addresses stay word aligned
    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        pc_valid |-> (pc[1:0] == 2'b00)
    ) else $error("pc_gen: misaligned fetch pc %h", pc);

endmodule

`default_nettype wire

// File: common/fe_pkg.sv
`default_nettype none

package fe_pkg;

    localparam logic [31:0] reset_pc = 32'h8000_0000;  // first fetch address

    // fetch queue sizing
    localparam int fq_depth = 4;
    localparam int fq_ptr_w = $clog2(fq_depth);
    localparam int fq_cnt_w = $clog2(fq_depth + 1);  // count must reach fq_depth

    // major opcodes seen by decode
    localparam logic [6:0] op_op  = 7'b0110011;  // R-type integer ops
    localparam logic [6:0] op_jal = 7'b1101111;

    localparam logic [6:0] funct7_muldiv = 7'b0000001;  // M extension

    // kind codes handed to the back end
    localparam logic [1:0] kind_alu    = 2'd0;
    localparam logic [1:0] kind_muldiv = 2'd1;
    localparam logic [1:0] kind_jal    = 2'd2;
    localparam logic [1:0] kind_other  = 2'd3;

    // one instruction word, read either as R-type or as J-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic       imm20;     // sign bit
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

endpackage

`default_nettype wire
